/* avi_packet_top.f */
verilog/hdmi_aux_pkg.sv
verilog/bch_parity.sv
verilog/avi_field_capture.sv
verilog/avi_info_frame.sv
verilog/packet_assembler.sv
verilog/avi_packet_top.sv
verif/avi_packet_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the AVI packet testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps \
    --top-module avi_packet_tb \
    -f avi_packet_top.f \
    -o avi_packet_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/avi_packet_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST OK" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Pass message not found in sim.log"
    exit 1
fi

/* verif/avi_packet_tb.sv */
////////////////////////////////////////////////////////////////////////////
// AVI InfoFrame packet testbench
// Table of field sets, reference packets, random output stalls
////////////////////////////////////////////////////////////////////////////
module avi_packet_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import hdmi_aux_pkg::*;

    typedef struct packed
    {
        field2_t    video_format;
        logic       active_format_present;
        field2_t    bar_info;
        field2_t    scan_info;
        field2_t    colorimetry;
        field2_t    picture_aspect;
        nibble_t    active_format_aspect;
        logic       it_content;
        ext_color_t ext_colorimetry;
        field2_t    rgb_quant_range;
        field2_t    nonuniform_scaling;
        vic_t       video_id_code;
        field2_t    ycc_quant_range;
        field2_t    content_type;
        nibble_t    pixel_repetition;
    } entry_t;

    // Header stream in bits 0..31, subpacket i at 32 + 64*i, parity on top
    typedef logic [287:0] pkt_bits_t;

    localparam int         NUM_ENTRIES   = 8;
    localparam int         PACKET_CYCLES = 32;
    localparam int         WAIT_LIMIT    = 2000;         // Cycles per wait
    localparam logic [7:0] PARITY_FEEDBACK = 8'b1000_0011;  // x^8+x^7+x^6+1, LSB first

    // VF AFP BAR SCAN C M R ITC EC Q SC / VIC YQ CN PR
    entry_t stim [NUM_ENTRIES] = '{
        '{2'd0, 1'b1, 2'd0, 2'd0, 2'd1, 2'd1, 4'd8, 1'b0, 3'd0, 2'd1, 2'd0,
          7'd1, 2'd0, 2'd0, 4'd0},    // 640x480
        '{2'd1, 1'b1, 2'd3, 2'd1, 2'd2, 2'd2, 4'd8, 1'b1, 3'd0, 2'd2, 2'd0,
          7'd4, 2'd0, 2'd1, 4'd0},    // 720p, both bars
        '{2'd2, 1'b1, 2'd0, 2'd2, 2'd2, 2'd2, 4'd9, 1'b0, 3'd0, 2'd0, 2'd3,
          7'd16, 2'd1, 2'd2, 4'd0},   // 1080p
        '{2'd1, 1'b0, 2'd1, 2'd1, 2'd1, 2'd1, 4'd10, 1'b0, 3'd0, 2'd1, 2'd1,
          7'd6, 2'd0, 2'd0, 4'd1},    // 480i, doubled pixels
        '{2'd2, 1'b1, 2'd2, 2'd2, 2'd3, 2'd2, 4'd8, 1'b1, 3'd4, 2'd2, 2'd0,
          7'd31, 2'd1, 2'd3, 4'd0},   // Extended colorimetry
        '{2'd0, 1'b1, 2'd3, 2'd0, 2'd3, 2'd2, 4'd11, 1'b0, 3'd6, 2'd2, 2'd2,
          7'd97, 2'd0, 2'd3, 4'd3},
        '{2'd1, 1'b1, 2'd0, 2'd1, 2'd1, 2'd1, 4'd13, 1'b1, 3'd1, 2'd1, 2'd0,
          7'd21, 2'd1, 2'd1, 4'd1},   // 576i
        '{2'd2, 1'b0, 2'd2, 2'd0, 2'd2, 2'd2, 4'd15, 1'b0, 3'd0, 2'd0, 2'd1,
          7'd95, 2'd0, 2'd2, 4'd9}
    };

    logic        clk_pixel = 1'b0;
    logic        rst_n;
    logic        in_valid;
    logic        in_ready;
    entry_t      cur;                 // Field set on the input ports
    logic        out_ready = 1'b0;
    logic        out_valid;
    logic        out_hdr_bit;
    logic [7:0]  out_sub_bits;
    logic        out_first;
    logic        out_last;
    logic [11:0] out_bundle;          // All out_ ports for stall checks
    logic [11:0] stalled_outs;
    logic        was_stalled = 1'b0;
    logic        hold_low = 1'b1;     // Sink blocked
    logic [31:0] lcg_state = 32'he94ebf87;
    pkt_bits_t   rx = '0;
    int          cyc = 0;
    int          pkt_count = 0;
    int          in_accepted = 0;
    int          checks = 0;
    int          errors = 0;

    assign out_bundle = {out_valid, out_hdr_bit, out_sub_bits, out_first, out_last};

    always #20 clk_pixel = ~clk_pixel;

    avi_packet_top u_dut
    (
        .*,
        .video_format          (cur.video_format),
        .active_format_present (cur.active_format_present),
        .bar_info              (cur.bar_info),
        .scan_info             (cur.scan_info),
        .colorimetry           (cur.colorimetry),
        .picture_aspect        (cur.picture_aspect),
        .active_format_aspect  (cur.active_format_aspect),
        .it_content            (cur.it_content),
        .ext_colorimetry       (cur.ext_colorimetry),
        .rgb_quant_range       (cur.rgb_quant_range),
        .nonuniform_scaling    (cur.nonuniform_scaling),
        .video_id_code         (cur.video_id_code),
        .ycc_quant_range       (cur.ycc_quant_range),
        .content_type          (cur.content_type),
        .pixel_repetition      (cur.pixel_repetition)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Serial BCH over nbits message bits, bit 0 first
    function automatic logic [7:0] bch_parity_of(input logic [63:0] msg, input int nbits);
        logic [7:0] r;
        logic       fb;
        r = 8'h00;
        for (int b = 0; b < nbits; b++)
        begin
            fb = r[0] ^ msg[b];
            r  = r >> 1;
            if (fb)
                r = r ^ PARITY_FEEDBACK;
        end
        return r;
    endfunction

    // Reference packet as it should appear on the wire
    function automatic pkt_bits_t expected_packet(input entry_t e);
        logic [7:0]  pb [28];
        logic [23:0] hdr;
        logic [7:0]  sum;
        logic [63:0] msg;
        pkt_bits_t   p;
        hdr = 24'h0D0282;                     // Length 13, version 2, type 0x82
        for (int k = 0; k < 28; k++)
            pb[k] = 8'h00;
        pb[1][6:5] = e.video_format;          // Y1 Y0
        pb[1][4]   = e.active_format_present;
        pb[1][3:2] = e.bar_info;
        pb[1][1:0] = e.scan_info;
        pb[2][7:6] = e.colorimetry;
        pb[2][5:4] = e.picture_aspect;
        pb[2][3:0] = e.active_format_aspect;
        pb[3][7]   = e.it_content;
        pb[3][6:4] = e.ext_colorimetry;
        pb[3][3:2] = e.rgb_quant_range;
        pb[3][1:0] = e.nonuniform_scaling;
        pb[4][6:0] = e.video_id_code;
        pb[5][7:6] = e.ycc_quant_range;
        pb[5][5:4] = e.content_type;
        pb[5][3:0] = e.pixel_repetition;
        if (e.bar_info != 2'b00)
        begin
            pb[6]  = 8'hFF;
            pb[7]  = 8'hFF;
            pb[10] = 8'hFF;
            pb[11] = 8'hFF;
        end
        sum = hdr[7:0] + hdr[15:8] + hdr[23:16];
        for (int k = 1; k < 14; k++)
            sum = sum + pb[k];
        pb[0] = ~sum + 8'h01;                 // Two's complement of the rest
        p = '0;
        p[23:0]  = hdr;
        p[31:24] = bch_parity_of({40'h0, hdr}, 24);
        for (int i = 0; i < 4; i++)
        begin
            msg = 64'h0;
            for (int k = 0; k < 7; k++)
                msg[8*k +: 8] = pb[7*i + k];
            msg[63:56] = bch_parity_of(msg, 56);
            p[32 + 64*i +: 64] = msg;
        end
        return p;
    endfunction

    // PBk out of a received packet
    function automatic logic [7:0] rx_byte(input pkt_bits_t p, input int k);
        return p[32 + 64*(k/7) + 8*(k%7) +: 8];
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("CHECK FAILED at %0t: %s got 0x%0h expected 0x%0h",
                     $time, name, got, exp);
        end
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    task automatic check_packet(input int k, input pkt_bits_t p);
        pkt_bits_t  exp;
        logic [7:0] sum;
        logic [7:0] bar;
        if (k >= NUM_ENTRIES)
        begin
            report_problem("a packet arrived after the whole table was sent");
            return;
        end
        exp = expected_packet(stim[k]);
        check_value($sformatf("pkt%0d header", k), 64'(p[23:0]), 64'(24'h0D0282));
        check_value($sformatf("pkt%0d header parity", k), 64'(p[31:24]), 64'(exp[31:24]));
        for (int i = 0; i < 4; i++)
        begin
            check_value($sformatf("pkt%0d sub%0d data", k, i),
                        64'(p[32 + 64*i +: 56]), 64'(exp[32 + 64*i +: 56]));
            check_value($sformatf("pkt%0d sub%0d parity", k, i),
                        64'(p[88 + 64*i +: 8]), 64'(exp[88 + 64*i +: 8]));
        end
        sum = p[7:0] + p[15:8] + p[23:16];   // Header plus PB0..PB13
        for (int b = 0; b < 14; b++)
            sum = sum + rx_byte(p, b);
        check_value($sformatf("pkt%0d checksum total", k), 64'(sum), 64'h0);
        for (int b = 6; b < 14; b++)
        begin
            // 00 00 FF FF twice, counting down from PB13
            bar = (stim[k].bar_info != 2'b00 && ((13 - b) % 4) >= 2) ? 8'hFF : 8'h00;
            check_value($sformatf("pkt%0d PB%0d", k, b), 64'(rx_byte(p, b)), 64'(bar));
        end
    endtask

    // Random sink stalls, about one cycle in four
    always @(posedge clk_pixel)
    begin
        #2;
        lcg_state = lcg_next(lcg_state);
        out_ready = !hold_low && (lcg_state[31:30] != 2'b00);
    end

    // Output monitor, sampled mid-cycle
    always @(negedge clk_pixel)
    begin
        if (rst_n)
        begin
            if (in_valid && in_ready)
                in_accepted++;
            if (was_stalled)
                check_value("out_* held under stall", 64'(out_bundle), 64'(stalled_outs));
            was_stalled  = out_valid && !out_ready;
            stalled_outs = out_bundle;
            if (out_valid && out_ready)
            begin
                check_value("out_first", 64'(out_first), 64'(cyc == 0));
                check_value("out_last", 64'(out_last), 64'(cyc == PACKET_CYCLES - 1));
                if (cyc < PACKET_CYCLES)
                begin
                    rx[cyc] = out_hdr_bit;
                    for (int i = 0; i < 4; i++)
                    begin
                        rx[32 + 64*i + 2*cyc]     = out_sub_bits[2*i];      // Even bit
                        rx[32 + 64*i + 2*cyc + 1] = out_sub_bits[2*i + 1];
                    end
                end
                cyc++;
                if (out_last)
                begin
                    check_value("accepted cycles per packet", 64'(cyc), 64'(PACKET_CYCLES));
                    check_packet(pkt_count, rx);
                    pkt_count++;
                    cyc = 0;
                end
            end
        end
    end

    // Every table entry through in_valid/in_ready
    task automatic send_table();
        int waited;
        for (int k = 0; k < NUM_ENTRIES; k++)
        begin
            in_valid = 1'b1;
            cur      = stim[k];
            waited   = 0;
            @(negedge clk_pixel);
            while (!in_ready && waited < WAIT_LIMIT)
            begin
                @(negedge clk_pixel);
                waited++;
            end
            if (!in_ready)
            begin
                report_problem($sformatf("in_ready never rose for entry %0d", k));
                in_valid = 1'b0;
                return;
            end
            @(posedge clk_pixel);            // Transfer edge
            #2;
        end
        in_valid = 1'b0;
    endtask

    // Sink blocked long enough for all stages to fill
    task automatic hold_then_release();
        repeat (50) @(negedge clk_pixel);
        #1;
        check_value("in_ready while sink blocked", 64'(in_ready), 64'd0);
        checks++;
        assert (in_accepted <= 3)
        else
            report_problem($sformatf("%0d field sets taken while sink blocked", in_accepted));
        hold_low = 1'b0;
    endtask

    initial
    begin
        int waited;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        cur      = '0;
        repeat (4) @(posedge clk_pixel);
        #2;
        rst_n = 1'b1;
        @(negedge clk_pixel);
        check_value("out_valid after reset", 64'(out_valid), 64'd0);
        check_value("in_ready after reset", 64'(in_ready), 64'd1);
        @(posedge clk_pixel);
        #2;
        fork
            send_table();
            hold_then_release();
        join
        waited = 0;
        while (pkt_count < NUM_ENTRIES && waited < WAIT_LIMIT)
        begin
            @(posedge clk_pixel);
            waited++;
        end
        if (pkt_count < NUM_ENTRIES)
            report_problem($sformatf("only %0d of %0d packets arrived", pkt_count, NUM_ENTRIES));
        // Output stays quiet once the table is drained
        repeat (2 * PACKET_CYCLES)
        begin
            @(negedge clk_pixel);
            check_value("out_valid after last packet", 64'(out_valid), 64'd0);
        end
        $display("Checks: %0d, errors: %0d, packets: %0d", checks, errors, pkt_count);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

/* verilog/avi_packet_top.sv */
////////////////////////////////////////////////////////////////////////////
// AVI InfoFrame packet top level
// Capture, frame builder and packet assembler in a pipeline
////////////////////////////////////////////////////////////////////////////
module avi_packet_top
(
    input  logic                     clk_pixel,
    input  logic                     rst_n,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  hdmi_aux_pkg::field2_t    video_format,
    input  logic                     active_format_present,
    input  hdmi_aux_pkg::field2_t    bar_info,
    input  hdmi_aux_pkg::field2_t    scan_info,
    input  hdmi_aux_pkg::field2_t    colorimetry,
    input  hdmi_aux_pkg::field2_t    picture_aspect,
    input  hdmi_aux_pkg::nibble_t    active_format_aspect,
    input  logic                     it_content,
    input  hdmi_aux_pkg::ext_color_t ext_colorimetry,
    input  hdmi_aux_pkg::field2_t    rgb_quant_range,
    input  hdmi_aux_pkg::field2_t    nonuniform_scaling,
    input  hdmi_aux_pkg::vic_t       video_id_code,
    input  hdmi_aux_pkg::field2_t    ycc_quant_range,
    input  hdmi_aux_pkg::field2_t    content_type,
    input  hdmi_aux_pkg::nibble_t    pixel_repetition,
    input  logic                     out_ready,
    output logic                     out_valid,
    output logic                     out_hdr_bit,   // Channel 0 bit 2
    output logic [7:0]               out_sub_bits,  // Channels 1 and 2
    output logic                     out_first,
    output logic                     out_last
);
    import hdmi_aux_pkg::*;

    // Capture to builder
    logic       cap_valid;
    logic       cap_ready;
    field2_t    cap_video_format;
    logic       cap_active_format_present;
    field2_t    cap_bar_info;
    field2_t    cap_scan_info;
    field2_t    cap_colorimetry;
    field2_t    cap_picture_aspect;
    nibble_t    cap_active_format_aspect;
    logic       cap_it_content;
    ext_color_t cap_ext_colorimetry;
    field2_t    cap_rgb_quant_range;
    field2_t    cap_nonuniform_scaling;
    vic_t       cap_video_id_code;
    field2_t    cap_ycc_quant_range;
    field2_t    cap_content_type;
    nibble_t    cap_pixel_repetition;

    // Builder to assembler
    logic       frm_valid;
    logic       frm_ready;
    header_t    frm_header;
    subpacket_t frm_sub0;
    subpacket_t frm_sub1;
    subpacket_t frm_sub2;
    subpacket_t frm_sub3;

    // Port names match across stages
    avi_field_capture u_capture (.*);

    avi_info_frame    u_builder (.*);

    packet_assembler  u_assembler (.*);

endmodule

/* verilog/packet_assembler.sv */
////////////////////////////////////////////////////////////////////////////
// Data island packet assembler
// Serializes header and subpackets over 32 cycles and appends BCH parity
////////////////////////////////////////////////////////////////////////////
module packet_assembler
(
    input  logic                     clk_pixel,
    input  logic                     rst_n,
    input  logic                     frm_valid,
    input  hdmi_aux_pkg::header_t    frm_header,
    input  hdmi_aux_pkg::subpacket_t frm_sub0,
    input  hdmi_aux_pkg::subpacket_t frm_sub1,
    input  hdmi_aux_pkg::subpacket_t frm_sub2,
    input  hdmi_aux_pkg::subpacket_t frm_sub3,
    input  logic                     out_ready,
    output logic                     frm_ready,
    output logic                     out_valid,
    output logic                     out_hdr_bit,
    output logic [7:0]               out_sub_bits,  // Pair per subpacket, even bit first
    output logic                     out_first,
    output logic                     out_last
);
    import hdmi_aux_pkg::*;

    localparam cycle_idx_t LAST_IDX = cycle_idx_t'(PKT_CYCLES - 1);

    asm_state_e state;
    cycle_idx_t cycle_idx;   // Cycle currently on the outputs
    header_t    hdr_sr;      // Header bits, LSB out first
    subpacket_t sub_sr [4];  // Subpacket bits, two per cycle
    ecc_t       hdr_par;
    ecc_t       sub_par [4];
    cycle_idx_t hdr_off;     // Position within header parity
    cycle_idx_t sub_off;     // Position within subpacket parity
    logic       accept;
    logic       load;
    logic       hdr_data;
    logic       sub_data;

    assign accept    = out_valid & out_ready;
    assign frm_ready = (state == ASM_IDLE) | (accept & out_last);  // Back to back
    assign load      = frm_valid & frm_ready;
    assign hdr_data  = cycle_idx < cycle_idx_t'(HDR_DATA_CYCLES);
    assign sub_data  = cycle_idx < cycle_idx_t'(SUB_DATA_CYCLES);
    assign hdr_off   = cycle_idx - cycle_idx_t'(HDR_DATA_CYCLES);
    assign sub_off   = cycle_idx - cycle_idx_t'(SUB_DATA_CYCLES);

    // FSM with registered framing flags
    always_ff @(posedge clk_pixel)
    begin
        if (!rst_n)
        begin
            state     <= ASM_IDLE;
            cycle_idx <= '0;
            out_valid <= 1'b0;
            out_first <= 1'b0;
            out_last  <= 1'b0;
        end
        else if (load)
        begin
            state     <= ASM_SEND;
            cycle_idx <= '0;
            out_valid <= 1'b1;
            out_first <= 1'b1;
            out_last  <= 1'b0;
        end
        else if (accept)
        begin
            out_first <= 1'b0;
            if (out_last)
            begin
                state     <= ASM_IDLE;  // No frame waiting
                out_valid <= 1'b0;
                out_last  <= 1'b0;
            end
            else
            begin
                cycle_idx <= cycle_idx + 1'b1;
                out_last  <= (cycle_idx == LAST_IDX - 1'b1);
            end
        end
    end

    // Payload shift registers, no reset
    always_ff @(posedge clk_pixel)
    begin
        if (load)
        begin
            hdr_sr    <= frm_header;
            sub_sr[0] <= frm_sub0;
            sub_sr[1] <= frm_sub1;
            sub_sr[2] <= frm_sub2;
            sub_sr[3] <= frm_sub3;
        end
        else if (accept)
        begin
            if (hdr_data)
                hdr_sr <= hdr_sr >> 1;
            if (sub_data)
                for (int i = 0; i < 4; i++)
                    sub_sr[i] <= sub_sr[i] >> 2;
        end
    end

    // Data first, then parity LSB first
    assign out_hdr_bit = hdr_data ? hdr_sr[0] : hdr_par[hdr_off[2:0]];

    bch_parity #(.BITS_PER_STEP(1)) u_hdr_bch
    (
        .clk_pixel (clk_pixel),
        .rst_n     (rst_n),
        .clr       (load),
        .step      (accept & hdr_data),
        .data_bits ({1'b0, hdr_sr[0]}),
        .parity    (hdr_par)
    );

    for (genvar i = 0; i < 4; i++)
    begin : g_sub
        assign out_sub_bits[2*i +: 2] = sub_data ? sub_sr[i][1:0] :
            {sub_par[i][{sub_off[1:0], 1'b1}], sub_par[i][{sub_off[1:0], 1'b0}]};

        bch_parity #(.BITS_PER_STEP(2)) u_sub_bch
        (
            .clk_pixel (clk_pixel),
            .rst_n     (rst_n),
            .clr       (load),
            .step      (accept & sub_data),
            .data_bits (sub_sr[i][1:0]),
            .parity    (sub_par[i])
        );
    end

    a_idle_quiet: assert property (@(posedge clk_pixel) disable iff (!rst_n)
        state == ASM_IDLE |-> !out_valid);

    a_last_cycle: assert property (@(posedge clk_pixel) disable iff (!rst_n)
        out_last |-> cycle_idx == LAST_IDX);

endmodule

/* verilog/avi_info_frame.sv */
////////////////////////////////////////////////////////////////////////////
// AVI InfoFrame builder
// Forms header, checksum and four registered subpackets from a field set
////////////////////////////////////////////////////////////////////////////
module avi_info_frame
(
    input  logic                     clk_pixel,
    input  logic                     rst_n,
    input  logic                     cap_valid,
    input  hdmi_aux_pkg::field2_t    cap_video_format,
    input  logic                     cap_active_format_present,
    input  hdmi_aux_pkg::field2_t    cap_bar_info,
    input  hdmi_aux_pkg::field2_t    cap_scan_info,
    input  hdmi_aux_pkg::field2_t    cap_colorimetry,
    input  hdmi_aux_pkg::field2_t    cap_picture_aspect,
    input  hdmi_aux_pkg::nibble_t    cap_active_format_aspect,
    input  logic                     cap_it_content,
    input  hdmi_aux_pkg::ext_color_t cap_ext_colorimetry,
    input  hdmi_aux_pkg::field2_t    cap_rgb_quant_range,
    input  hdmi_aux_pkg::field2_t    cap_nonuniform_scaling,
    input  hdmi_aux_pkg::vic_t       cap_video_id_code,
    input  hdmi_aux_pkg::field2_t    cap_ycc_quant_range,
    input  hdmi_aux_pkg::field2_t    cap_content_type,
    input  hdmi_aux_pkg::nibble_t    cap_pixel_repetition,
    input  logic                     frm_ready,
    output logic                     cap_ready,
    output logic                     frm_valid,
    output hdmi_aux_pkg::header_t    frm_header,
    output hdmi_aux_pkg::subpacket_t frm_sub0,   // PB0..PB6
    output hdmi_aux_pkg::subpacket_t frm_sub1,   // PB7..PB13
    output hdmi_aux_pkg::subpacket_t frm_sub2,   // PB14..PB20, reserved
    output hdmi_aux_pkg::subpacket_t frm_sub3    // PB21..PB27, reserved
);
    import hdmi_aux_pkg::*;

    header_t    header;
    pb_byte_t   pb [28];
    subpacket_t sub [4];
    logic       take;  // Cap handshake

    assign header    = {AVI_LENGTH, AVI_VERSION, AVI_TYPE};
    assign cap_ready = ~frm_valid | frm_ready;  // Empty or draining now
    assign take      = cap_valid & cap_ready;

    always_comb
    begin
        pb_byte_t sum;
        pb    = '{default: 8'h00};
        pb[1] = {1'b0, cap_video_format, cap_active_format_present,
                 cap_bar_info, cap_scan_info};
        pb[2] = {cap_colorimetry, cap_picture_aspect, cap_active_format_aspect};
        pb[3] = {cap_it_content, cap_ext_colorimetry, cap_rgb_quant_range,
                 cap_nonuniform_scaling};
        pb[4] = {1'b0, cap_video_id_code};
        pb[5] = {cap_ycc_quant_range, cap_content_type, cap_pixel_repetition};
        if (cap_bar_info != 2'b00)
        begin
            // Bar pattern, PB13 down is 00 00 FF FF 00 00 FF FF
            pb[6]  = 8'hFF;
            pb[7]  = 8'hFF;
            pb[10] = 8'hFF;
            pb[11] = 8'hFF;
        end
        sum = header[7:0] + header[15:8] + header[23:16];
        for (int k = 1; k < 14; k++)
            sum = sum + pb[k];
        pb[0] = 8'h00 - sum;  // Whole frame sums to zero
        for (int s = 0; s < 4; s++)
            for (int k = 0; k < 7; k++)
                sub[s][8*k +: 8] = pb[7*s + k];
    end

    always_ff @(posedge clk_pixel)
    begin
        if (!rst_n)
            frm_valid <= 1'b0;
        else if (take)
            frm_valid <= 1'b1;
        else if (frm_ready)
            frm_valid <= 1'b0;  // Assembler took it
    end

    always_ff @(posedge clk_pixel)
    begin
        if (take)
        begin
            frm_header <= header;
            frm_sub0   <= sub[0];
            frm_sub1   <= sub[1];
            frm_sub2   <= sub[2];
            frm_sub3   <= sub[3];
        end
    end

    a_frm_hold: assert property (@(posedge clk_pixel) disable iff (!rst_n)
        frm_valid && !frm_ready |=> frm_valid &&
        $stable({frm_header, frm_sub0, frm_sub1, frm_sub2, frm_sub3}));

endmodule

/* verilog/avi_field_capture.sv */
////////////////////////////////////////////////////////////////////////////
// AVI field capture
// One-entry buffer that holds an accepted field set for the frame builder
////////////////////////////////////////////////////////////////////////////
module avi_field_capture
(
    input  logic                     clk_pixel,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  logic                     cap_ready,
    input  hdmi_aux_pkg::field2_t    video_format,       // RGB, 422, 444
    input  logic                     active_format_present,
    input  hdmi_aux_pkg::field2_t    bar_info,
    input  hdmi_aux_pkg::field2_t    scan_info,
    input  hdmi_aux_pkg::field2_t    colorimetry,
    input  hdmi_aux_pkg::field2_t    picture_aspect,
    input  hdmi_aux_pkg::nibble_t    active_format_aspect,
    input  logic                     it_content,
    input  hdmi_aux_pkg::ext_color_t ext_colorimetry,    // Valid when colorimetry is 3
    input  hdmi_aux_pkg::field2_t    rgb_quant_range,
    input  hdmi_aux_pkg::field2_t    nonuniform_scaling,
    input  hdmi_aux_pkg::vic_t       video_id_code,
    input  hdmi_aux_pkg::field2_t    ycc_quant_range,
    input  hdmi_aux_pkg::field2_t    content_type,
    input  hdmi_aux_pkg::nibble_t    pixel_repetition,
    output logic                     in_ready,
    output logic                     cap_valid,
    output hdmi_aux_pkg::field2_t    cap_video_format,
    output logic                     cap_active_format_present,
    output hdmi_aux_pkg::field2_t    cap_bar_info,
    output hdmi_aux_pkg::field2_t    cap_scan_info,
    output hdmi_aux_pkg::field2_t    cap_colorimetry,
    output hdmi_aux_pkg::field2_t    cap_picture_aspect,
    output hdmi_aux_pkg::nibble_t    cap_active_format_aspect,
    output logic                     cap_it_content,
    output hdmi_aux_pkg::ext_color_t cap_ext_colorimetry,
    output hdmi_aux_pkg::field2_t    cap_rgb_quant_range,
    output hdmi_aux_pkg::field2_t    cap_nonuniform_scaling,
    output hdmi_aux_pkg::vic_t       cap_video_id_code,
    output hdmi_aux_pkg::field2_t    cap_ycc_quant_range,
    output hdmi_aux_pkg::field2_t    cap_content_type,
    output hdmi_aux_pkg::nibble_t    cap_pixel_repetition
);
    import hdmi_aux_pkg::*;

    logic full;    // Entry occupied
    logic accept;  // Input transfer this edge

    assign in_ready  = ~full;
    assign cap_valid = full;
    assign accept    = in_valid & in_ready;

    always_ff @(posedge clk_pixel)
    begin
        if (!rst_n)
            full <= 1'b0;
        else if (accept)
            full <= 1'b1;
        else if (cap_ready)
            full <= 1'b0;  // Builder took the set
    end

    // Field payload, no reset
    always_ff @(posedge clk_pixel)
    begin
        if (accept)
        begin
            cap_video_format          <= video_format;
            cap_active_format_present <= active_format_present;
            cap_bar_info              <= bar_info;
            cap_scan_info             <= scan_info;
            cap_colorimetry           <= colorimetry;
            cap_picture_aspect        <= picture_aspect;
            cap_active_format_aspect  <= active_format_aspect;
            cap_it_content            <= it_content;
            cap_ext_colorimetry       <= ext_colorimetry;
            cap_rgb_quant_range       <= rgb_quant_range;
            cap_nonuniform_scaling    <= nonuniform_scaling;
            cap_video_id_code         <= video_id_code;
            cap_ycc_quant_range       <= ycc_quant_range;
            cap_content_type          <= content_type;
            cap_pixel_repetition      <= pixel_repetition;
        end
    end

    // Source must hold valid and fields until the transfer
    a_in_stable: assert property (@(posedge clk_pixel) disable iff (!rst_n)
        in_valid && !in_ready |=> in_valid && $stable({video_format,
        active_format_present, bar_info, scan_info, colorimetry, picture_aspect,
        active_format_aspect, it_content, ext_colorimetry, rgb_quant_range,
        nonuniform_scaling, video_id_code, ycc_quant_range, content_type,
        pixel_repetition}));

endmodule

/* verilog/bch_parity.sv */
////////////////////////////////////////////////////////////////////////////
// Serial BCH parity for data island packets
// BCH(32,24) at one bit per step, BCH(64,56) at two
////////////////////////////////////////////////////////////////////////////
module bch_parity
#(
    parameter int BITS_PER_STEP = 1  // 1 or 2
)
(
    input  logic               clk_pixel,
    input  logic               rst_n,
    input  logic               clr,        // Start of a new message
    input  logic               step,       // Fold in data_bits
    input  logic [1:0]         data_bits,  // Bit 0 first
    output hdmi_aux_pkg::ecc_t parity
);
    import hdmi_aux_pkg::*;

    ecc_t par_next;

    // LSB-first LFSR, one iteration per message bit
    always_comb
    begin
        par_next = parity;
        for (int b = 0; b < BITS_PER_STEP; b++)
        begin
            if (par_next[0] ^ data_bits[b])
                par_next = (par_next >> 1) ^ BCH_POLY;
            else
                par_next = par_next >> 1;
        end
    end

    always_ff @(posedge clk_pixel)
    begin
        if (!rst_n || clr)
            parity <= '0;
        else if (step)
            parity <= par_next;  // Holds between steps and after the last one
    end

endmodule

/* verilog/hdmi_aux_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// HDMI auxiliary packet definitions for the AVI InfoFrame path
// Packet constants, field widths and assembler states
////////////////////////////////////////////////////////////////////////////
package hdmi_aux_pkg;

    typedef logic [7:0]  pb_byte_t;    // One packet byte
    typedef logic [23:0] header_t;     // HB2 HB1 HB0, HB0 in low byte
    typedef logic [55:0] subpacket_t;  // Seven bytes, PB(7i) in low byte
    typedef logic [7:0]  ecc_t;        // BCH parity byte
    typedef logic [6:0]  vic_t;        // Video ID code
    typedef logic [1:0]  field2_t;     // Generic 2-bit field code
    typedef logic [2:0]  ext_color_t;  // Extended colorimetry EC2..EC0
    typedef logic [3:0]  nibble_t;     // AF aspect, pixel repetition
    typedef logic [4:0]  cycle_idx_t;  // Cycle within a data island packet

    // InfoFrame flag in bit 7 over type 2
    localparam pb_byte_t AVI_TYPE    = 8'h82;
    localparam pb_byte_t AVI_VERSION = 8'h02;
    localparam pb_byte_t AVI_LENGTH  = 8'h0D;

    localparam int PKT_CYCLES      = 32;  // Cycles per packet
    localparam int HDR_DATA_CYCLES = 24;  // Header payload, then 8 parity
    localparam int SUB_DATA_CYCLES = 28;  // Subpacket payload, then 4 parity

    // x^8 + x^7 + x^6 + 1, reflected for an LSB-first shift
    localparam ecc_t BCH_POLY = 8'b1000_0011;

    typedef enum logic
    {
        ASM_IDLE,  // Waiting for a frame
        ASM_SEND   // Serializing 32 cycles
    } asm_state_e;

endpackage
